//--- fme_config.svh
`ifndef FME_CONFIG_SVH
`define FME_CONFIG_SVH

// ****************************************
// data widths
// ****************************************

`define FME_PIXEL_WIDTH 8 // reference pixel
`define FME_HBUF_WIDTH 16 // horizontal half-sample intermediate
`define FME_SUM_WIDTH 24 // signed filter accumulator

// ****************************************
// filter geometry
// ****************************************

`define FME_TAP_NUM 8 // rows per column window
`define FME_VLANES 8 // columns on the vertical path
`define FME_DLANES 9 // columns on the diagonal path

// ****************************************
// output normalization
// ****************************************

// vertical path works on plain pixels, so one 6-bit gain
`define FME_VSHIFT 6
// diagonal path carries the horizontal gain as well
`define FME_DSHIFT 12

`endif

//--- fme_half_filter.sv
`timescale 1ns/1ps

`include "fme_config.svh"

module fme_half_filter #(
	parameter type taps_t = fme_pkg::vtaps_t,
	parameter type sum_row_t = fme_pkg::vsum_row_t,
	parameter int LANES = `FME_VLANES
) (
	input taps_t taps_i, // oldest row at index 0
	output sum_row_t sum_o // unscaled filter result per column
);

	// ****************************************
	// per-column multiply-accumulate
	// ****************************************

	// Each column is filtered on its own. The tap words are widened to the
	// accumulator width first: pixel words are unsigned and extend with zero,
	// intermediate words carry a sign and extend with it, which the element
	// type of the row decides.
	always_comb begin
		fme_pkg::sum_t acc;
		fme_pkg::sum_t ext;

		sum_o = '0;
		for (int l = 0; l < LANES; l++) begin
			acc = '0;
			for (int t = 0; t < `FME_TAP_NUM; t++) begin
				ext = taps_i[t].lane[l]; // width follows word signedness
				acc = acc + ext * fme_pkg::tap_coef[t];
			end
			sum_o[l] = acc;
		end
	end

endmodule

//--- fme_pkg.sv
`include "fme_config.svh"

package fme_pkg;

	// ****************************************
	// scalar words
	// ****************************************

	typedef logic [`FME_PIXEL_WIDTH-1:0] pel_t; // unsigned pixel
	typedef logic signed [`FME_HBUF_WIDTH-1:0] hbuf_t; // signed intermediate
	typedef logic signed [`FME_SUM_WIDTH-1:0] sum_t; // accumulator

	// ****************************************
	// rows, one word per column
	// ****************************************

	typedef struct packed {
		pel_t [`FME_VLANES-1:0] lane; // lane 0 in the low bits
	} vrow_t;

	typedef struct packed {
		hbuf_t [`FME_DLANES-1:0] lane;
	} hrow_t;

	typedef struct packed {
		pel_t [`FME_DLANES-1:0] lane;
	} drow_t;

	typedef sum_t [`FME_VLANES-1:0] vsum_row_t;
	typedef sum_t [`FME_DLANES-1:0] dsum_row_t;

	// window of rows, index 0 is the oldest
	typedef vrow_t [`FME_TAP_NUM-1:0] vtaps_t;
	typedef hrow_t [`FME_TAP_NUM-1:0] htaps_t;

	// hevc half-sample luma filter, gain 64
	localparam sum_t tap_coef [`FME_TAP_NUM] = '{
		-1, 4, -11, 40, 40, -11, 4, -1
	};

endpackage

//--- fme_round_clip.sv
`timescale 1ns/1ps

`include "fme_config.svh"

module fme_round_clip #(
	parameter type sum_row_t = fme_pkg::vsum_row_t,
	parameter type out_row_t = fme_pkg::vrow_t,
	parameter int LANES = `FME_VLANES,
	parameter int SHIFT = `FME_VSHIFT
) (
	input logic clk,
	input logic rstn,

	input sum_row_t sum_i, // raw filter sums
	input logic en_i, // full window on a valid beat

	output logic valid_o,
	output out_row_t row_o
);

	// ****************************************
	// normalization constants
	// ****************************************

	localparam fme_pkg::sum_t RND = fme_pkg::sum_t'(2 ** (SHIFT - 1)); // half lsb
	localparam fme_pkg::sum_t PEL_MAX = fme_pkg::sum_t'((1 << `FME_PIXEL_WIDTH) - 1);

	out_row_t clip_row; // combinational result

	// ****************************************
	// round, shift, clip
	// ****************************************

	always_comb begin
		fme_pkg::sum_t scaled;

		clip_row = '0;
		for (int l = 0; l < LANES; l++) begin
			scaled = (sum_i[l] + RND) >>> SHIFT; // keep sign through shift
			if (scaled < 0) begin
				clip_row.lane[l] = '0;
			end else if (scaled > PEL_MAX) begin
				clip_row.lane[l] = '1;
			end else begin
				clip_row.lane[l] = fme_pkg::pel_t'(scaled);
			end
		end
	end

	// ****************************************
	// output register
	// ****************************************

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			valid_o <= 1'b0;
		end else begin
			valid_o <= en_i; // one cycle per full beat
		end
	end

	always_ff @(posedge clk) begin
		if (en_i) begin
			row_o <= clip_row; // holds until the next full beat
		end
	end

endmodule

//--- fme_tap_window.sv
`timescale 1ns/1ps

`include "fme_config.svh"

module fme_tap_window #(
	parameter type row_t = logic [`FME_PIXEL_WIDTH-1:0],
	parameter int DEPTH = `FME_TAP_NUM
) (
	input logic clk,
	input logic rstn,

	input logic start_i, // first row of a block
	input logic valid_i, // row accepted this edge
	input row_t row_i,

	output row_t [DEPTH-1:0] taps_o, // oldest at index 0
	output logic full_o // enough history for a window
);

	// ****************************************
	// local state
	// ****************************************

	localparam int CNT_W = $clog2(DEPTH);
	localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(DEPTH - 1);

	row_t [DEPTH-2:0] hist_q; // stored rows, newest at DEPTH-2
	logic [CNT_W-1:0] fill_q; // rows seen since last start

	// ****************************************
	// delay line
	// ****************************************

	// the whole column history moves one step per accepted row
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			hist_q <= '0;
		end else if (valid_i) begin
			hist_q <= {row_i, hist_q[DEPTH-2:1]}; // drop the oldest
		end
	end

	// ****************************************
	// fill tracking
	// ****************************************

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			fill_q <= '0;
		end else if (valid_i) begin
			if (start_i) begin
				fill_q <= CNT_W'(1); // start row counts itself
			end else if (fill_q != CNT_FULL) begin
				fill_q <= fill_q + 1'b1; // saturate once full
			end
		end
	end

	// current row closes the window as the newest tap
	assign taps_o = {row_i, hist_q};

	// a start beat always opens a fresh, short window
	assign full_o = !start_i && (fill_q == CNT_FULL);

endmodule

//--- fme_vhalf_interp.f
+incdir+.
fme_pkg.sv
fme_tap_window.sv
fme_half_filter.sv
fme_round_clip.sv
fme_vhalf_interp.sv
fme_vhalf_interp_assert.sv
tb_fme_vhalf_interp.sv

//--- fme_vhalf_interp.sv
`timescale 1ns/1ps

`include "fme_config.svh"

module fme_vhalf_interp (
	input logic clk,
	input logic rstn,

	// vertical path, reference pixels
	input logic refpel_start_i,
	input logic refpel_valid_i,
	input fme_pkg::vrow_t ref_row_i,
	output logic vhalf_valid_o,
	output fme_pkg::vrow_t vhalf_row_o,

	// diagonal path, horizontal half-sample intermediates
	input logic hbuf_start_i,
	input logic hbuf_valid_i,
	input fme_pkg::hrow_t hbuf_row_i,
	output logic diag_valid_o,
	output fme_pkg::drow_t diag_row_o
);

	// ****************************************
	// vertical path
	// ****************************************

	fme_pkg::vtaps_t vtaps;
	fme_pkg::vsum_row_t vsum;
	logic vfull;

	fme_tap_window #(
		.row_t(fme_pkg::vrow_t),
		.DEPTH(`FME_TAP_NUM)
	) u_vwin (
		.clk(clk),
		.rstn(rstn),
		.start_i(refpel_start_i),
		.valid_i(refpel_valid_i),
		.row_i(ref_row_i),
		.taps_o(vtaps),
		.full_o(vfull)
	);

	fme_half_filter #(
		.taps_t(fme_pkg::vtaps_t),
		.sum_row_t(fme_pkg::vsum_row_t),
		.LANES(`FME_VLANES)
	) u_vfilt (
		.taps_i(vtaps),
		.sum_o(vsum)
	);

	fme_round_clip #(
		.sum_row_t(fme_pkg::vsum_row_t),
		.out_row_t(fme_pkg::vrow_t),
		.LANES(`FME_VLANES),
		.SHIFT(`FME_VSHIFT)
	) u_vout (
		.clk(clk),
		.rstn(rstn),
		.sum_i(vsum),
		.en_i(refpel_valid_i && vfull), // only full windows leave
		.valid_o(vhalf_valid_o),
		.row_o(vhalf_row_o)
	);

	// ****************************************
	// diagonal path
	// ****************************************

	fme_pkg::htaps_t htaps;
	fme_pkg::dsum_row_t dsum;
	logic dfull;

	fme_tap_window #(
		.row_t(fme_pkg::hrow_t),
		.DEPTH(`FME_TAP_NUM)
	) u_dwin (
		.clk(clk),
		.rstn(rstn),
		.start_i(hbuf_start_i),
		.valid_i(hbuf_valid_i),
		.row_i(hbuf_row_i),
		.taps_o(htaps),
		.full_o(dfull)
	);

	fme_half_filter #(
		.taps_t(fme_pkg::htaps_t),
		.sum_row_t(fme_pkg::dsum_row_t),
		.LANES(`FME_DLANES)
	) u_dfilt (
		.taps_i(htaps),
		.sum_o(dsum)
	);

	fme_round_clip #(
		.sum_row_t(fme_pkg::dsum_row_t),
		.out_row_t(fme_pkg::drow_t),
		.LANES(`FME_DLANES),
		.SHIFT(`FME_DSHIFT)
	) u_dout (
		.clk(clk),
		.rstn(rstn),
		.sum_i(dsum),
		.en_i(hbuf_valid_i && dfull),
		.valid_o(diag_valid_o),
		.row_o(diag_row_o)
	);

endmodule

//--- fme_vhalf_interp_assert.sv
`timescale 1ns/1ps

module fme_vhalf_interp_assert (
	input logic clk,
	input logic rstn,
	input logic refpel_start_i,
	input logic refpel_valid_i,
	input logic vhalf_valid_o,
	input logic hbuf_start_i,
	input logic hbuf_valid_i,
	input logic diag_valid_o
);

	// ****************************************
	// reset behavior
	// ****************************************

	a_no_valid_in_reset: assert property (@(posedge clk) !rstn |-> !vhalf_valid_o && !diag_valid_o)
		else $error("output valid during reset");

	// ****************************************
	// fill rule
	// ****************************************

	a_vert_start_gap: assert property (@(posedge clk) disable iff (!rstn)
		refpel_start_i && refpel_valid_i |=> !vhalf_valid_o)
		else $error("vertical output right after a start beat");

	a_diag_start_gap: assert property (@(posedge clk) disable iff (!rstn)
		hbuf_start_i && hbuf_valid_i |=> !diag_valid_o)
		else $error("diagonal output right after a start beat");

	// every output traces back to an accepted row
	a_vert_cause: assert property (@(posedge clk) disable iff (!rstn)
		vhalf_valid_o |-> $past(refpel_valid_i))
		else $error("vertical output without input row");

	a_diag_cause: assert property (@(posedge clk) disable iff (!rstn)
		diag_valid_o |-> $past(hbuf_valid_i))
		else $error("diagonal output without input row");

endmodule

bind fme_vhalf_interp fme_vhalf_interp_assert i_assert (
	.clk(clk),
	.rstn(rstn),
	.refpel_start_i(refpel_start_i),
	.refpel_valid_i(refpel_valid_i),
	.vhalf_valid_o(vhalf_valid_o),
	.hbuf_start_i(hbuf_start_i),
	.hbuf_valid_i(hbuf_valid_i),
	.diag_valid_o(diag_valid_o)
);

//--- fme_vhalf_vectors.txt
# columns: path(v|d) start valid row_hex expected_hex, '-' means no output valid expected
# v rows hold 8 pixels, d rows 9 intermediates, lane 0 in the rightmost digits
v 1 1 f0c8966432190a00 -
v 0 1 f0c8966432190a00 -
v 0 1 f0c8966432190a00 -
v 0 1 f0c8966432190a00 -
v 0 1 f0c8966432190a00 -
v 0 1 f0c8966432190a00 -
v 0 1 f0c8966432190a00 -
v 0 1 f0c8966432190a00 f0c8966432190a00
v 0 1 f0c8966432190a00 f0c8966432190a00
v 0 0 0 -
v 0 1 f0c8966432190a00 f0c8966432190a00
v 1 1 0 -
v 0 1 0 -
v 0 1 0 -
v 0 1 0 -
v 0 1 ff80400000000000 -
v 0 1 0 -
v 0 1 0 -
v 0 1 0 9f50280000000000
v 0 0 0 -
v 0 1 0 9f50280000000000
v 0 1 0 0000000000000000
v 0 0 0 -
v 0 0 0 -
v 0 1 0 1008040000000000
v 0 1 0 0000000000000000
v 0 1 0 0000000000000000
v 1 1 0102030405060708 -
v 0 1 0102030405060708 -
v 0 1 0102030405060708 -
v 0 1 0102030405060708 -
v 1 1 0102030405060708 -
v 0 1 0102030405060708 -
v 0 1 0102030405060708 -
v 0 1 0102030405060708 -
v 0 1 0102030405060708 -
v 0 1 0102030405060708 -
v 0 1 0102030405060708 -
v 0 1 0102030405060708 0102030405060708
d 1 1 7fff800010002000 3fc040000020001fffe0 -
d 0 1 7fff800010002000 3fc040000020001fffe0 -
d 0 1 7fff800010002000 3fc040000020001fffe0 -
d 0 1 7fff800010002000 3fc040000020001fffe0 -
d 0 1 7fff800010002000 3fc040000020001fffe0 -
d 0 1 7fff800010002000 3fc040000020001fffe0 -
d 0 1 7fff800010002000 3fc040000020001fffe0 -
d 0 1 7fff800010002000 3fc040000020001fffe0 ff004080ffff010000
d 0 0 0 -
d 0 1 7fff800010002000 3fc040000020001fffe0 ff004080ffff010000
d 1 1 0 -
d 0 1 0 -
d 0 1 0 -
d 0 1 0 -
d 0 1 7fff80000c001999000100346000ff000400 -
d 0 1 0 -
d 0 1 0 -
d 0 1 0 ff001e400001f0000a
d 0 1 0 ff001e400001f0000a
d 0 0 0 -
d 0 1 0 005800000000000100
d 0 1 0 200003060000180001
d 0 1 0 000800000000000000
d 0 1 0 000000000000000000
d 1 1 0 -
d 0 1 0 -
d 1 1 0 -
d 0 1 0 -
d 0 1 0 -
d 0 1 0 -
d 0 1 0 -
d 0 1 0 -
d 0 1 0 -
d 0 1 0 000000000000000000

//--- run_sim.sh
#!/bin/sh
# build and run the fme_vhalf_interp testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_fme_vhalf_interp \
	-f fme_vhalf_interp.f \
	-o sim_fme_vhalf_interp

./obj_dir/sim_fme_vhalf_interp > sim.log 2>&1 || true
cat sim.log

if grep -q "Test failed" sim.log; then
	echo "simulation reported failure"
	exit 1
fi

if ! grep -q "Test completed successfully" sim.log; then
	echo "simulation ended without a result"
	exit 1
fi

exit 0

//--- tb_fme_vhalf_interp.sv
`timescale 1ns/1ps

`include "fme_config.svh"

module tb_fme_vhalf_interp;

	localparam int RAND_BEATS = 400;
	localparam int CLK_PERIOD = 10;

	logic clk;
	logic rstn;
	logic refpel_start_i;
	logic refpel_valid_i;
	fme_pkg::vrow_t ref_row_i;
	logic vhalf_valid_o;
	fme_pkg::vrow_t vhalf_row_o;
	logic hbuf_start_i;
	logic hbuf_valid_i;
	fme_pkg::hrow_t hbuf_row_i;
	logic diag_valid_o;
	fme_pkg::drow_t diag_row_o;

	int value_errs = 0;
	int other_errs = 0;
	int total_beats = 0;
	integer seed = 32'ha2d9;

	// half-sample luma filter as written in the HEVC spec
	int coef [8] = '{-1, 4, -11, 40, 40, -11, 4, -1};

	// reference model state, index 6 is the newest stored row
	fme_pkg::vrow_t vhist [7];
	fme_pkg::hrow_t dhist [7];
	int vfill = 0;
	int dfill = 0;

	// vectors from file
	bit is_diag_q [$];
	bit start_q [$];
	bit valid_q [$];
	bit chk_q [$];
	logic [143:0] row_q [$];
	logic [71:0] exp_q [$];

	fme_vhalf_interp i_dut (.*);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// ****************************************
	// compare tasks
	// ****************************************

	task automatic check_vrow(string name, fme_pkg::vrow_t act, fme_pkg::vrow_t exp);
		if (act !== exp) begin
			$display("error %0t %s act=%h exp=%h", $time, name, act, exp);
			value_errs++;
		end
	endtask

	task automatic check_drow(string name, fme_pkg::drow_t act, fme_pkg::drow_t exp);
		if (act !== exp) begin
			$display("error %0t %s act=%h exp=%h", $time, name, act, exp);
			value_errs++;
		end
	endtask

	task automatic check_valid(string name, logic act, logic exp);
		if (act !== exp) begin
			$display("error %0t %s act=%b exp=%b", $time, name, act, exp);
			value_errs++;
		end
	endtask

	// ****************************************
	// reference model
	// ****************************************

	function automatic int scale_and_clip(int sum, int shift);
		int r;
		r = (sum + (1 << (shift - 1))) >>> shift;
		if (r < 0) r = 0;
		if (r > 255) r = 255;
		return r;
	endfunction

	task automatic model_vert(input bit st, input bit vl, input fme_pkg::vrow_t row,
			output bit exp_vl, output fme_pkg::vrow_t exp_row);
		int sum;
		int pel;
		exp_vl = vl && !st && (vfill >= 7);
		exp_row = '0;
		for (int l = 0; l < `FME_VLANES; l++) begin
			sum = 0;
			for (int t = 0; t < 8; t++) begin
				pel = (t == 7) ? int'(row.lane[l]) : int'(vhist[t].lane[l]); // unsigned
				sum += pel * coef[t];
			end
			exp_row.lane[l] = 8'(scale_and_clip(sum, `FME_VSHIFT));
		end
		if (vl) begin
			vfill = st ? 1 : vfill + 1;
			for (int k = 0; k < 6; k++) vhist[k] = vhist[k + 1];
			vhist[6] = row;
		end
	endtask

	task automatic model_diag(input bit st, input bit vl, input fme_pkg::hrow_t row,
			output bit exp_vl, output fme_pkg::drow_t exp_row);
		int sum;
		int h;
		exp_vl = vl && !st && (dfill >= 7);
		exp_row = '0;
		for (int l = 0; l < `FME_DLANES; l++) begin
			sum = 0;
			for (int t = 0; t < 8; t++) begin
				h = (t == 7) ? int'(row.lane[l]) : int'(dhist[t].lane[l]); // signed words
				sum += h * coef[t];
			end
			exp_row.lane[l] = 8'(scale_and_clip(sum, `FME_DSHIFT));
		end
		if (vl) begin
			dfill = st ? 1 : dfill + 1;
			for (int k = 0; k < 6; k++) dhist[k] = dhist[k + 1];
			dhist[6] = row;
		end
	endtask

	// ****************************************
	// vector file
	// ****************************************

	function automatic bit is_space(byte c);
		return c == " " || c == "\t" || c == "\n" || c == "\r";
	endfunction

	task automatic read_vectors();
		int fd;
		int r;
		int st;
		int vl;
		string line;
		string word;
		string words [$];
		string tag;
		string row_s;
		string exp_s;
		logic [143:0] row_w;
		logic [71:0] exp_w;
		fd = $fopen("fme_vhalf_vectors.txt", "r");
		if (fd == 0) begin
			$display("could not open the vector file fme_vhalf_vectors.txt");
			other_errs++;
			return;
		end
		forever begin
			r = $fgets(line, fd);
			if (r == 0) break;
			words = {};
			word = "";
			for (int k = 0; k < line.len(); k++) begin
				if (is_space(line[k])) begin
					if (word.len() > 0) words.push_back(word);
					word = "";
				end else begin
					word = {word, line.substr(k, k)};
				end
			end
			if (word.len() > 0) words.push_back(word);
			if (words.size() == 0) continue;
			tag = words[0];
			if (tag[0] == "#") continue; // comment text
			if (words.size() < 5) begin
				$display("malformed line in the vector file after tag %s", tag);
				other_errs++;
				break;
			end
			r = $sscanf(words[1], "%d", st);
			r = $sscanf(words[2], "%d", vl);
			// long rows may come in several digit groups
			row_s = "";
			for (int k = 3; k < words.size() - 1; k++) begin
				row_s = {row_s, words[k]};
			end
			exp_s = words[words.size() - 1];
			row_w = '0;
			r = $sscanf(row_s, "%h", row_w);
			exp_w = '0;
			if (exp_s != "-") r = $sscanf(exp_s, "%h", exp_w);
			is_diag_q.push_back(tag == "d");
			start_q.push_back(st != 0);
			valid_q.push_back(vl != 0);
			row_q.push_back(row_w);
			chk_q.push_back(exp_s != "-");
			exp_q.push_back(exp_w);
		end
		$fclose(fd);
	endtask

	// model and check one beat; inputs already driven at the falling edge
	task automatic run_beat(input bit file_chk, input bit file_diag, input bit file_vld,
			input logic [71:0] file_exp);
		bit ev;
		bit ed;
		fme_pkg::vrow_t vexp;
		fme_pkg::drow_t dexp;
		model_vert(refpel_start_i, refpel_valid_i, ref_row_i, ev, vexp);
		model_diag(hbuf_start_i, hbuf_valid_i, hbuf_row_i, ed, dexp);
		@(posedge clk);
		@(negedge clk);
		check_valid("vhalf_valid_o", vhalf_valid_o, ev);
		check_valid("diag_valid_o", diag_valid_o, ed);
		if (ev) check_vrow("vhalf_row_o", vhalf_row_o, vexp);
		if (ed) check_drow("diag_row_o", diag_row_o, dexp);
		if (file_vld && !file_diag) begin
			check_valid("vhalf_valid_o", vhalf_valid_o, file_chk);
			if (file_chk) check_vrow("vhalf_row_o", vhalf_row_o, file_exp[63:0]);
		end
		if (file_vld && file_diag) begin
			check_valid("diag_valid_o", diag_valid_o, file_chk);
			if (file_chk) check_drow("diag_row_o", diag_row_o, file_exp);
		end
	endtask

	// ****************************************
	// watchdog
	// ****************************************

	initial begin
		wait (total_beats > 0);
		#((total_beats + 50) * CLK_PERIOD);
		$display("timeout: the run did not reach its end in the expected time");
		$display("Test failed");
		$finish;
	end

	// ****************************************
	// main sequence
	// ****************************************

	initial begin
		clk = 1'b0;
		rstn = 1'b0;
		refpel_start_i = 1'b0;
		refpel_valid_i = 1'b0;
		ref_row_i = '0;
		hbuf_start_i = 1'b0;
		hbuf_valid_i = 1'b0;
		hbuf_row_i = '0;
		for (int k = 0; k < 7; k++) begin
			vhist[k] = '0;
			dhist[k] = '0;
		end

		read_vectors();
		total_beats = is_diag_q.size() + RAND_BEATS + 2;

		repeat (2) @(posedge clk);
		@(negedge clk);
		rstn = 1'b1;

		// directed part, one line per cycle
		for (int i = 0; i < is_diag_q.size(); i++) begin
			refpel_valid_i = !is_diag_q[i] && valid_q[i];
			refpel_start_i = !is_diag_q[i] && start_q[i];
			ref_row_i = row_q[i][63:0];
			hbuf_valid_i = is_diag_q[i] && valid_q[i];
			hbuf_start_i = is_diag_q[i] && start_q[i];
			hbuf_row_i = row_q[i];
			run_beat(chk_q[i], is_diag_q[i], 1'b1, exp_q[i]);
		end

		// random stream on both paths with gaps
		for (int i = 0; i < RAND_BEATS; i++) begin
			refpel_valid_i = ($random(seed) & 3) != 0;
			refpel_start_i = refpel_valid_i && (($random(seed) & 15) == 0);
			for (int l = 0; l < `FME_VLANES; l++) ref_row_i.lane[l] = 8'($random(seed));
			hbuf_valid_i = ($random(seed) & 3) != 0;
			hbuf_start_i = hbuf_valid_i && (($random(seed) & 15) == 0);
			for (int l = 0; l < `FME_DLANES; l++) begin
				hbuf_row_i.lane[l] = 16'($random(seed) % 8192); // mostly mid range
			end
			run_beat(1'b0, 1'b0, 1'b0, '0);
		end

		$display("value errors: %0d, other errors: %0d", value_errs, other_errs);
		if (value_errs == 0 && other_errs == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule
